// ==== build.f ====
+incdir+include
hw/chan_link_pkg.sv
hw/chan_stream_fifo.sv
hw/chan_lane_stage.sv
hw/chan_io_block.sv
hw/chan_link_top.sv
testbench/chan_link_tb.sv

// ==== hw/chan_io_block.sv ====
// ################################################
// programming interface register block
// control, status readback, error counters
// ################################################

`timescale 1ns/100ps

`include "chan_link_settings.svh"

module chan_io_block (
  input  logic                      aurora_user_clk,
  input  logic                      arst_n,
  input  chan_link_pkg::io_req_t    io_req,
  input  logic                      channel_up,
  input  logic                      readout_pause,
  input  logic [4:0]                tx_count,     // tx FIFO fill
  input  logic [4:0]                rx_count,     // rx FIFO fill
  input  logic                      frame_err,    // bad keep pulse
  input  logic                      drop,         // rx FIFO overflow pulse
  output logic [31:0]               io_rd_data,
  output logic                      io_rd_ack,
  output chan_link_pkg::link_ctrl_t ctrl
);

  logic                   acc;
  logic                   wr;
  logic                   rd;
  logic [31:0]            rd_mux;
  logic [1:0]             cnt_evt;                 // 0 frame error, 1 drop
  logic [1:0]             cnt_clr;
  logic [`CHAN_CNT_W-1:0] cnt [2];

  assign acc = io_req.sel & io_req.sync;           // accepted on this edge
  assign wr  = acc & io_req.wr_en;
  assign rd  = acc & io_req.rd_en;

  assign cnt_evt    = {drop, frame_err};
  assign cnt_clr[0] = wr & (io_req.addr == chan_link_pkg::REG_FRAME_ERR);
  assign cnt_clr[1] = wr & (io_req.addr == chan_link_pkg::REG_DROP);

  // control register
  always_ff @(posedge aurora_user_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= '0;
    end else if (wr && io_req.addr == chan_link_pkg::REG_CTRL) begin
      ctrl.link_enable <= io_req.wr_data[0];
      ctrl.loopback    <= io_req.wr_data[3:1];
    end
  end

  // saturating counters, a write clears
  for (genvar i = 0; i < 2; i++) begin : g_cnt
    always_ff @(posedge aurora_user_clk or negedge arst_n) begin
      if (!arst_n) begin
        cnt[i] <= '0;
      end else if (cnt_clr[i]) begin
        cnt[i] <= '0;                              // clear wins over an event
      end else if (cnt_evt[i] && cnt[i] != '1) begin
        cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  // readback mux
  always_comb begin
    rd_mux = '0;                                   // unknown addresses read zero
    case (io_req.addr)
      chan_link_pkg::REG_CTRL: begin
        rd_mux[0]   = ctrl.link_enable;
        rd_mux[3:1] = ctrl.loopback;
      end
      chan_link_pkg::REG_STATUS: begin
        rd_mux[0]     = channel_up;
        rd_mux[1]     = readout_pause;
        rd_mux[12:8]  = tx_count;
        rd_mux[20:16] = rx_count;
      end
      chan_link_pkg::REG_FRAME_ERR: rd_mux[`CHAN_CNT_W-1:0] = cnt[0];
      chan_link_pkg::REG_DROP:      rd_mux[`CHAN_CNT_W-1:0] = cnt[1];
      default:                      rd_mux = '0;
    endcase
  end

  // data and ack one cycle after the request
  always_ff @(posedge aurora_user_clk or negedge arst_n) begin
    if (!arst_n) begin
      io_rd_data <= '0;
      io_rd_ack  <= 1'b0;
    end else begin
      io_rd_ack <= rd;
      if (rd) begin
        io_rd_data <= rd_mux;
      end
    end
  end

endmodule

// ==== hw/chan_lane_stage.sv ====
// ################################################
// lane stage, tx out or internal loopback
// keep check on every received beat, channel_up
// ################################################

`timescale 1ns/100ps

module chan_lane_stage (
  input  logic                      aurora_user_clk,
  input  logic                      arst_n,
  input  chan_link_pkg::link_ctrl_t ctrl,            // enable and loopback
  input  chan_link_pkg::beat_t      tx_beat,         // from tx FIFO
  input  logic                      tx_valid,
  output logic                      tx_ready,
  output chan_link_pkg::beat_t      lane_tx_beat,    // to the lane
  output logic                      lane_tx_strobe,
  input  chan_link_pkg::beat_t      lane_rx_beat,    // from the lane, no stall
  input  logic                      lane_rx_strobe,
  input  logic                      lane_up,
  output chan_link_pkg::beat_t      rx_beat,         // checked beats to rx FIFO
  output logic                      rx_strobe,
  output logic                      frame_err,       // pulse per bad beat
  output logic                      channel_up
);

  logic                        loop;
  logic                        tx_fire;
  chan_link_pkg::beat_t        loop_beat;            // looped beat, one cycle old
  logic                        loop_valid;
  chan_link_pkg::beat_t        chk_beat;
  logic                        chk_valid;
  chan_link_pkg::keep_class_e  keep_class;

  assign loop     = (ctrl.loopback != 3'b000);
  assign tx_ready = ctrl.link_enable;              // lane never stalls when enabled
  assign tx_fire  = tx_valid & tx_ready;

  // looped beat takes priority, external only outside loopback
  assign chk_valid = loop_valid | (lane_rx_strobe & ~loop);
  assign chk_beat  = loop_valid ? loop_beat : lane_rx_beat;

  // keep must be full, or a contiguous head on the last beat
  always_comb begin
    case (chk_beat.keep)
      4'b1111: keep_class = chan_link_pkg::KEEP_FULL;
      4'b1110,
      4'b1100,
      4'b1000: keep_class = chk_beat.last ? chan_link_pkg::KEEP_TAIL
                                          : chan_link_pkg::KEEP_BAD;
      default: keep_class = chan_link_pkg::KEEP_BAD;
    endcase
  end

  always_ff @(posedge aurora_user_clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_tx_beat   <= '0;
      lane_tx_strobe <= 1'b0;
      loop_beat      <= '0;
      loop_valid     <= 1'b0;
      rx_beat        <= '0;
      rx_strobe      <= 1'b0;
      frame_err      <= 1'b0;
      channel_up     <= 1'b0;
    end else begin
      lane_tx_strobe <= tx_fire & ~loop;           // nothing on the lane in loopback
      loop_valid     <= tx_fire & loop;
      if (tx_fire) begin
        lane_tx_beat <= tx_beat;
        loop_beat    <= tx_beat;
      end
      rx_strobe <= chk_valid & (keep_class != chan_link_pkg::KEEP_BAD);
      frame_err <= chk_valid & (keep_class == chan_link_pkg::KEEP_BAD);
      if (chk_valid) begin
        rx_beat <= chk_beat;
      end
      channel_up <= loop | lane_up;                // loopback is always up
    end
  end

endmodule

// ==== hw/chan_link_pkg.sv ====
// ################################################
// channel link package
// stream beat, programming request and control types
// ################################################

package chan_link_pkg;

  // one 32-bit stream beat, keep[3] marks the first byte
  typedef struct packed {
    logic [31:0] data;                  // payload word
    logic [3:0]  keep;                  // byte enables, msb first
    logic        last;                  // end of frame
  } beat_t;

  // programming interface request
  typedef struct packed {
    logic        sel;                   // block selected
    logic        sync;                  // start of operation
    logic        rd_en;                 // read cycle
    logic        wr_en;                 // write cycle
    logic [19:0] addr;                  // register address
    logic [31:0] wr_data;               // write payload
  } io_req_t;

  // link control from the register block
  typedef struct packed {
    logic       link_enable;            // let tx beats into the lane
    logic [2:0] loopback;               // nonzero selects internal loopback
  } link_ctrl_t;

  // register map
  typedef enum logic [19:0] {
    REG_CTRL      = 20'h0,              // rw, link_enable and loopback
    REG_STATUS    = 20'h1,              // ro, up, pause, fill counts
    REG_FRAME_ERR = 20'h2,              // frame errors, write clears
    REG_DROP      = 20'h3               // dropped rx beats, write clears
  } reg_addr_e;

  // keep pattern classification of a received beat
  typedef enum logic [1:0] {
    KEEP_FULL = 2'd0,                   // all four bytes
    KEEP_TAIL = 2'd1,                   // contiguous partial on last beat
    KEEP_BAD  = 2'd2                    // anything else
  } keep_class_e;

endpackage

// ==== hw/chan_link_top.sv ====
// ################################################
// channel link endpoint, user side of one lane
// tx FIFO, lane stage, rx FIFO, registers, pause
// ################################################

`timescale 1ns/100ps

`include "chan_link_settings.svh"

module chan_link_top (
  input  logic                   aurora_user_clk,
  input  logic                   arst_n,
  input  chan_link_pkg::beat_t   tx_beat,         // user tx stream
  input  logic                   tx_valid,
  output logic                   tx_ready,
  output chan_link_pkg::beat_t   rx_beat,         // user rx stream
  output logic                   rx_valid,
  input  logic                   rx_ready,
  output chan_link_pkg::beat_t   lane_tx_beat,    // parallel lane port
  output logic                   lane_tx_strobe,
  input  chan_link_pkg::beat_t   lane_rx_beat,
  input  logic                   lane_rx_strobe,
  input  logic                   lane_up,
  output logic                   readout_pause,   // rx fill above threshold
  input  chan_link_pkg::io_req_t io_req,          // programming interface
  output logic [31:0]            io_rd_data,
  output logic                   io_rd_ack
);

  localparam int CNT_W = $clog2(`CHAN_FIFO_DEPTH) + 1;

  chan_link_pkg::beat_t       fifo_tx_beat;       // tx FIFO to lane
  logic                       fifo_tx_valid;
  logic                       fifo_tx_ready;
  chan_link_pkg::beat_t       lane_rx_out;        // checked beats to rx FIFO
  logic                       lane_rx_out_strobe;
  logic [CNT_W-1:0]           tx_count;
  logic [CNT_W-1:0]           rx_count;
  logic                       rx_drop;
  logic                       frame_err;
  logic                       channel_up;
  chan_link_pkg::link_ctrl_t  ctrl;

  chan_stream_fifo tx_fifo (
    .aurora_user_clk(aurora_user_clk), .arst_n(arst_n),
    .wr_beat(tx_beat), .wr_valid(tx_valid), .wr_ready(tx_ready),
    .rd_beat(fifo_tx_beat), .rd_valid(fifo_tx_valid), .rd_ready(fifo_tx_ready),
    .count(tx_count),
    .drop()                                       // tx side is back-pressured
  );

  chan_lane_stage i_lane (
    .aurora_user_clk(aurora_user_clk), .arst_n(arst_n), .ctrl(ctrl),
    .tx_beat(fifo_tx_beat), .tx_valid(fifo_tx_valid), .tx_ready(fifo_tx_ready),
    .lane_tx_beat(lane_tx_beat), .lane_tx_strobe(lane_tx_strobe),
    .lane_rx_beat(lane_rx_beat), .lane_rx_strobe(lane_rx_strobe), .lane_up(lane_up),
    .rx_beat(lane_rx_out), .rx_strobe(lane_rx_out_strobe),
    .frame_err(frame_err), .channel_up(channel_up)
  );

  chan_stream_fifo rx_fifo (
    .aurora_user_clk(aurora_user_clk), .arst_n(arst_n),
    .wr_beat(lane_rx_out), .wr_valid(lane_rx_out_strobe),
    .wr_ready(),                                  // lane cannot stall, overflow shows as drop
    .rd_beat(rx_beat), .rd_valid(rx_valid), .rd_ready(rx_ready),
    .count(rx_count), .drop(rx_drop)
  );

  chan_io_block i_io (
    .aurora_user_clk(aurora_user_clk), .arst_n(arst_n), .io_req(io_req),
    .channel_up(channel_up), .readout_pause(readout_pause),
    .tx_count(tx_count), .rx_count(rx_count),
    .frame_err(frame_err), .drop(rx_drop),
    .io_rd_data(io_rd_data), .io_rd_ack(io_rd_ack), .ctrl(ctrl)
  );

  // pause upstream readout while rx FIFO is nearly full
  always_ff @(posedge aurora_user_clk or negedge arst_n) begin
    if (!arst_n) begin
      readout_pause <= 1'b0;
    end else begin
      readout_pause <= (rx_count > CNT_W'(`CHAN_PAUSE_THRESH));
    end
  end

endmodule

// ==== hw/chan_stream_fifo.sv ====
// ################################################
// synchronous stream FIFO with output register
// fill count, full drop pulse
// ################################################

`timescale 1ns/100ps

`include "chan_link_settings.svh"

module chan_stream_fifo (
  input  logic                 aurora_user_clk,
  input  logic                 arst_n,
  input  chan_link_pkg::beat_t wr_beat,       // write side
  input  logic                 wr_valid,
  output logic                 wr_ready,
  output chan_link_pkg::beat_t rd_beat,       // read side, registered
  output logic                 rd_valid,
  input  logic                 rd_ready,
  output logic [4:0]           count,         // total occupancy incl. output reg
  output logic                 drop           // write lost while full
);

  localparam int PTR_W = $clog2(`CHAN_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  chan_link_pkg::beat_t mem [`CHAN_FIFO_DEPTH];  // circular storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] mem_cnt;                     // entries still in mem
  logic             wr_fire;
  logic             pop;
  logic             load;

  assign wr_ready = (count != CNT_W'(`CHAN_FIFO_DEPTH)); // full counts the output reg too
  assign wr_fire  = wr_valid & wr_ready;
  assign pop      = rd_valid & rd_ready;
  assign mem_cnt  = count - CNT_W'(rd_valid);
  assign load     = (mem_cnt != '0) & (~rd_valid | pop); // refill output reg

  // beat storage
  always_ff @(posedge aurora_user_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  always_ff @(posedge aurora_user_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_beat  <= '0;
      rd_valid <= 1'b0;
      drop     <= 1'b0;
    end else begin
      drop <= wr_valid & ~wr_ready;     // one-cycle pulse per lost beat
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;        // wraps at depth
      end
      if (load) begin
        rd_beat  <= mem[rd_ptr];
        rd_valid <= 1'b1;
        rd_ptr   <= rd_ptr + 1'b1;
      end else if (pop) begin
        rd_valid <= 1'b0;               // drained
      end
      // read and write may coincide
      count <= count + CNT_W'(wr_fire) - CNT_W'(pop);
    end
  end

endmodule

// ==== include/chan_link_settings.svh ====
// ################################################
// channel link settings
// FIFO depth, pause threshold and counter width
// ################################################

`ifndef CHAN_LINK_SETTINGS_SVH
`define CHAN_LINK_SETTINGS_SVH

// beats held by each stream FIFO, power of two
`define CHAN_FIFO_DEPTH 16

// rx fill above which readout_pause is raised
`define CHAN_PAUSE_THRESH 12

// width of the saturating error counters
`define CHAN_CNT_W 16

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the channel link testbench with Verilator
# a failing check ends the run with $fatal, so the exit status is nonzero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f build.f --top-module chan_link_tb -Mdir obj_dir

./obj_dir/Vchan_link_tb

// ==== testbench/chan_link_tb.sv ====
// ################################################
// channel link testbench
// table-driven loopback, lane, overflow and register checks
// ################################################

`timescale 1ns/100ps

`include "chan_link_settings.svh"

module chan_link_tb;

  typedef struct packed {
    logic [3:0]                  keep;
    logic                        last;
    chan_link_pkg::keep_class_e  cls;          // expected classification
  } vec_t;

  localparam int          NUM_VEC        = 16;
  localparam int          TIMEOUT_CYCLES = 40 * NUM_VEC + 2000;
  localparam logic [31:0] LFSR_SEED      = 32'hf166;
  localparam int          PATH_LOOP      = 0;  // tx stream through internal loopback
  localparam int          PATH_LANE_TX   = 1;  // tx stream out on the lane
  localparam int          PATH_LANE_RX   = 2;  // strobed in on lane_rx

  localparam vec_t VEC_TABLE [NUM_VEC] = '{
    '{4'b1111, 1'b0, chan_link_pkg::KEEP_FULL},
    '{4'b1111, 1'b1, chan_link_pkg::KEEP_FULL},
    '{4'b1110, 1'b1, chan_link_pkg::KEEP_TAIL},
    '{4'b1100, 1'b1, chan_link_pkg::KEEP_TAIL},
    '{4'b1000, 1'b1, chan_link_pkg::KEEP_TAIL},
    '{4'b1110, 1'b0, chan_link_pkg::KEEP_BAD},  // partial on a non-last beat
    '{4'b0000, 1'b1, chan_link_pkg::KEEP_BAD},
    '{4'b0000, 1'b0, chan_link_pkg::KEEP_BAD},
    '{4'b1010, 1'b1, chan_link_pkg::KEEP_BAD},  // holes
    '{4'b0111, 1'b1, chan_link_pkg::KEEP_BAD},  // first byte missing
    '{4'b1111, 1'b0, chan_link_pkg::KEEP_FULL},
    '{4'b1001, 1'b1, chan_link_pkg::KEEP_BAD},
    '{4'b1111, 1'b1, chan_link_pkg::KEEP_FULL},
    '{4'b1100, 1'b0, chan_link_pkg::KEEP_BAD},
    '{4'b0101, 1'b1, chan_link_pkg::KEEP_BAD},
    '{4'b1111, 1'b0, chan_link_pkg::KEEP_FULL}
  };

  logic                   aurora_user_clk;
  logic                   arst_n;
  chan_link_pkg::beat_t   tx_beat;
  logic                   tx_valid;
  logic                   tx_ready;
  chan_link_pkg::beat_t   rx_beat;
  logic                   rx_valid;
  logic                   rx_ready;
  chan_link_pkg::beat_t   lane_tx_beat;
  logic                   lane_tx_strobe;
  chan_link_pkg::beat_t   lane_rx_beat;
  logic                   lane_rx_strobe;
  logic                   lane_up;
  logic                   readout_pause;
  chan_link_pkg::io_req_t io_req;
  logic [31:0]            io_rd_data;
  logic                   io_rd_ack;

  chan_link_pkg::beat_t   rx_expect [$];       // expected rx stream beats
  chan_link_pkg::beat_t   lane_expect [$];     // expected lane tx beats
  logic [31:0]            lfsr_state;
  logic                   lane_blocked;        // no lane traffic while the link is disabled
  int                     pause_fill;
  int                     cycle_cnt;

  chan_link_top i_chan_link_top (
    .aurora_user_clk(aurora_user_clk), .arst_n(arst_n),
    .tx_beat(tx_beat), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .rx_beat(rx_beat), .rx_valid(rx_valid), .rx_ready(rx_ready),
    .lane_tx_beat(lane_tx_beat), .lane_tx_strobe(lane_tx_strobe),
    .lane_rx_beat(lane_rx_beat), .lane_rx_strobe(lane_rx_strobe), .lane_up(lane_up),
    .readout_pause(readout_pause),
    .io_req(io_req), .io_rd_data(io_rd_data), .io_rd_ack(io_rd_ack)
  );

  always #4 aurora_user_clk = ~aurora_user_clk;  // 8 ns period

  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // galois step with taps x^32+x^30+x^26+x^25+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w          = {w[30:0], lfsr_state[0]};   // one bit per step
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge aurora_user_clk);
      #1;
    end
  endtask

  task automatic write_reg(input chan_link_pkg::reg_addr_e addr, input logic [31:0] data);
    io_req         = '0;
    io_req.sel     = 1'b1;
    io_req.sync    = 1'b1;
    io_req.wr_en   = 1'b1;
    io_req.addr    = addr;
    io_req.wr_data = data;
    idle(1);                                   // taken on this edge
    io_req = '0;
  endtask

  task automatic read_reg(input chan_link_pkg::reg_addr_e addr, output logic [31:0] data);
    check_value(64'(io_rd_ack), 64'(0), "io_rd_ack before read request");
    io_req       = '0;
    io_req.sel   = 1'b1;
    io_req.sync  = 1'b1;
    io_req.rd_en = 1'b1;
    io_req.addr  = addr;
    idle(1);
    io_req = '0;
    check_value(64'(io_rd_ack), 64'(1), "io_rd_ack one cycle after request");
    data = io_rd_data;
    idle(1);
    check_value(64'(io_rd_ack), 64'(0), "io_rd_ack longer than one cycle");
  endtask

  task automatic send_beat(input chan_link_pkg::beat_t b);
    logic taken;
    taken    = 1'b0;
    tx_beat  = b;
    tx_valid = 1'b1;
    while (!taken) begin
      @(negedge aurora_user_clk);
      taken = tx_ready;                        // transfer on the coming edge
      @(posedge aurora_user_clk);
      #1;
    end
    tx_valid = 1'b0;
  endtask

  // sends one full beat and queues it where it should appear
  task automatic send_full(input logic to_lane, input logic expected);
    chan_link_pkg::beat_t b;
    logic [31:0]          w;
    random_word(w);
    b.data = w;
    b.keep = 4'b1111;
    b.last = 1'b1;
    if (expected && to_lane) begin
      lane_expect.push_back(b);
    end else if (expected) begin
      rx_expect.push_back(b);
    end
    send_beat(b);
  endtask

  task automatic send_table(input int path, output int bad);
    chan_link_pkg::beat_t b;
    logic [31:0]          w;
    bad = 0;
    for (int i = 0; i < NUM_VEC; i++) begin
      random_word(w);
      b.data = w;
      b.keep = VEC_TABLE[i].keep;
      b.last = VEC_TABLE[i].last;
      if (VEC_TABLE[i].cls == chan_link_pkg::KEEP_BAD) begin
        bad++;
      end else if (path != PATH_LANE_TX) begin
        rx_expect.push_back(b);
      end
      if (path == PATH_LANE_TX) begin
        lane_expect.push_back(b);              // lane tx does no keep check
      end
      if (path == PATH_LANE_RX) begin
        lane_rx_beat   = b;
        lane_rx_strobe = 1'b1;                 // one beat per cycle
        idle(1);
      end else begin
        send_beat(b);
      end
    end
    lane_rx_strobe = 1'b0;
  endtask

  task automatic wait_drained();
    while (rx_expect.size() != 0 || lane_expect.size() != 0) begin
      idle(1);
    end
    idle(8);                                   // room for stray beats to show
  endtask

  task automatic wait_pause(input logic level);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge aurora_user_clk);
      #1;
      seen = (readout_pause == level);
    end
    pause_fill = rx_expect.size();             // fill model at the change
    idle(1);
  endtask

  // rx and lane tx monitor sampled mid-cycle
  always @(negedge aurora_user_clk) begin : out_monitor
    chan_link_pkg::beat_t exp_beat;
    if (arst_n && rx_valid && rx_ready) begin
      if (rx_expect.size() == 0) begin
        $display("rx stream delivered a beat at %0t ns that was not expected", $time);
        stop_with_failure();
      end else begin
        exp_beat = rx_expect.pop_front();
        check_value(64'(rx_beat), 64'(exp_beat), "rx_beat");
      end
    end
    if (arst_n && lane_tx_strobe) begin
      if (lane_blocked || lane_expect.size() == 0) begin
        $display("lane_tx_strobe rose at %0t ns when no lane beat was expected", $time);
        stop_with_failure();
      end else begin
        exp_beat = lane_expect.pop_front();
        check_value(64'(lane_tx_beat), 64'(exp_beat), "lane_tx_beat");
      end
    end
  end

  always @(posedge aurora_user_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout, run passed %0d cycles without finishing", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  initial begin
    logic [31:0]            rd_data;
    int                     bad_cnt;
    logic [`CHAN_CNT_W-1:0] drop_exp;
    aurora_user_clk = 1'b0;
    arst_n          = 1'b0;
    tx_beat         = '0;
    tx_valid        = 1'b0;
    rx_ready        = 1'b0;
    lane_rx_beat    = '0;
    lane_rx_strobe  = 1'b0;
    lane_up         = 1'b0;
    io_req          = '0;
    lfsr_state      = LFSR_SEED;
    lane_blocked    = 1'b0;
    cycle_cnt       = 0;
    repeat (10) @(posedge aurora_user_clk);
    #1;
    arst_n = 1'b1;

    check_value(64'(tx_ready), 64'(1), "tx_ready after reset");
    check_value(64'(rx_valid), 64'(0), "rx_valid after reset");
    check_value(64'(lane_tx_strobe), 64'(0), "lane_tx_strobe after reset");
    check_value(64'(readout_pause), 64'(0), "readout_pause after reset");
    read_reg(chan_link_pkg::REG_CTRL, rd_data);
    check_value(64'(rd_data), 64'(0), "REG_CTRL after reset");
    read_reg(chan_link_pkg::REG_FRAME_ERR, rd_data);
    check_value(64'(rd_data), 64'(0), "REG_FRAME_ERR after reset");
    read_reg(chan_link_pkg::REG_DROP, rd_data);
    check_value(64'(rd_data), 64'(0), "REG_DROP after reset");

    rx_ready = 1'b1;
    write_reg(chan_link_pkg::REG_CTRL, 32'h3);     // enable with loopback 001
    send_table(PATH_LOOP, bad_cnt);
    wait_drained();
    read_reg(chan_link_pkg::REG_STATUS, rd_data);
    check_value(64'(rd_data[0]), 64'(1), "channel_up in loopback");
    read_reg(chan_link_pkg::REG_FRAME_ERR, rd_data);
    check_value(64'(rd_data), 64'(bad_cnt), "REG_FRAME_ERR after loopback table");
    write_reg(chan_link_pkg::REG_FRAME_ERR, 32'h0);
    read_reg(chan_link_pkg::REG_FRAME_ERR, rd_data);
    check_value(64'(rd_data), 64'(0), "REG_FRAME_ERR after clear");

    rx_ready = 1'b0;                               // let the rx FIFO fill
    for (int i = 0; i < `CHAN_PAUSE_THRESH; i++) begin
      send_full(1'b0, 1'b1);
    end
    idle(6);
    check_value(64'(readout_pause), 64'(0), "readout_pause at threshold");
    read_reg(chan_link_pkg::REG_STATUS, rd_data);
    check_value(64'(rd_data[20:16]), 64'(`CHAN_PAUSE_THRESH), "rx count at threshold");
    check_value(64'(rd_data[1]), 64'(0), "REG_STATUS pause bit at threshold");
    send_full(1'b0, 1'b1);
    wait_pause(1'b1);
    read_reg(chan_link_pkg::REG_STATUS, rd_data);
    check_value(64'(rd_data[1]), 64'(1), "REG_STATUS pause bit above threshold");
    for (int i = `CHAN_PAUSE_THRESH + 1; i < 20; i++) begin
      send_full(1'b0, i < `CHAN_FIFO_DEPTH);       // beyond depth is dropped
    end
    idle(6);
    drop_exp = `CHAN_CNT_W'(20 - `CHAN_FIFO_DEPTH);
    read_reg(chan_link_pkg::REG_DROP, rd_data);
    check_value(64'(rd_data), 64'(drop_exp), "REG_DROP after overflow");
    rx_ready = 1'b1;
    wait_pause(1'b0);
    check_value(64'(pause_fill <= `CHAN_PAUSE_THRESH && pause_fill >= `CHAN_PAUSE_THRESH - 2),
                64'(1), "rx fill when readout_pause fell");
    wait_drained();

    write_reg(chan_link_pkg::REG_CTRL, 32'h1);     // enable with the external lane
    idle(2);
    read_reg(chan_link_pkg::REG_STATUS, rd_data);
    check_value(64'(rd_data[0]), 64'(0), "channel_up with lane down");
    lane_up = 1'b1;
    idle(2);
    read_reg(chan_link_pkg::REG_STATUS, rd_data);
    check_value(64'(rd_data[0]), 64'(1), "channel_up with lane up");
    send_table(PATH_LANE_TX, bad_cnt);
    wait_drained();
    send_table(PATH_LANE_RX, bad_cnt);
    wait_drained();
    read_reg(chan_link_pkg::REG_FRAME_ERR, rd_data);
    check_value(64'(rd_data), 64'(bad_cnt), "REG_FRAME_ERR after lane rx table");

    write_reg(chan_link_pkg::REG_CTRL, 32'h0);     // link disabled
    lane_blocked = 1'b1;
    for (int i = 0; i < `CHAN_FIFO_DEPTH; i++) begin
      send_full(1'b1, 1'b1);
    end
    check_value(64'(tx_ready), 64'(0), "tx_ready with tx FIFO full");
    idle(8);
    read_reg(chan_link_pkg::REG_STATUS, rd_data);
    check_value(64'(rd_data[12:8]), 64'(`CHAN_FIFO_DEPTH), "tx count while disabled");
    lane_blocked = 1'b0;
    write_reg(chan_link_pkg::REG_CTRL, 32'h1);
    wait_drained();
    check_value(64'(tx_ready), 64'(1), "tx_ready after release");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
